/* bench/icache_tb.sv */
// instruction cache testbench: clock, reset, AXI responder, stimulus table, checks, watchdog
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tb;
  import icache_pkg::*;

  localparam int num_rows   = 16;
  localparam int timeout_ns = num_rows * 64 * 8;

  // one table row: fetch or index invalidate, address, refill expected
  typedef struct packed {
    logic  cacop;
    addr_t addr;
    logic  refill;
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        req_valid_i;
  addr_t       req_addr_i;
  logic        req_ready_o;
  logic        rsp_valid_o;
  addr_t       rsp_addr_o;
  word_t       rsp_instr_o;
  logic        rsp_ready_i;
  logic        cacop_valid_i;
  addr_t       cacop_addr_i;
  logic        cacop_ready_o;
  logic        cacop_done_o;
  logic        ar_valid_o;
  addr_t       ar_addr_o;
  logic [7:0]  ar_len_o;
  logic        ar_ready_i;
  logic        r_valid_i;
  word_t       r_data_i;
  logic        r_last_i;
  logic        r_ready_o;

  row_t        stim [num_rows];
  addr_t       exp_q [$];
  logic        flag_q [$];
  int          errors;
  int          ar_count;
  int          ar_seen;
  int          rsp_count;
  int          done_count;
  int          exp_refills;
  int          exp_cacops;
  int          exp_fetches;
  logic        done_expect;

  icache_top dut0 (.*);

  always #4 clk = ~clk;

  // ==========================================================================
  // compare tasks and memory model
  // ==========================================================================
  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // every word holds its own address, scrambled
  function automatic word_t mem_word(input addr_t a);
    return {a[31:2], 2'b00} ^ 32'hA5A5_0000;
  endfunction

  function automatic addr_t line_base(input addr_t a);
    return a & ~addr_t'(`ICACHE_BLOCK_SIZE - 1);
  endfunction

  task automatic check_idle_outputs();
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    check_bit("cacop_done_o", cacop_done_o, 1'b0);
    check_bit("ar_valid_o", ar_valid_o, 1'b0);
    check_bit("r_ready_o", r_ready_o, 1'b0);
  endtask

  // lines A 0x1030, B 0x2030, C 0x3030 share index 3
  task automatic load_table();
    stim[0]  = '{1'b0, 32'h0000_1030, 1'b1};
    stim[1]  = '{1'b0, 32'h0000_1038, 1'b0};
    stim[2]  = '{1'b0, 32'h0000_2034, 1'b1};
    stim[3]  = '{1'b0, 32'h0000_1030, 1'b0};
    stim[4]  = '{1'b0, 32'h0000_3038, 1'b1};
    stim[5]  = '{1'b0, 32'h0000_1034, 1'b0};
    stim[6]  = '{1'b0, 32'h0000_203C, 1'b1};
    stim[7]  = '{1'b0, 32'h0000_4050, 1'b1};
    // way 0 of index 5
    stim[8]  = '{1'b1, 32'h0000_4050, 1'b0};
    stim[9]  = '{1'b0, 32'h0000_4058, 1'b1};
    stim[10] = '{1'b0, 32'h0000_4054, 1'b0};
    // way 0 of index 3 holds A
    stim[11] = '{1'b1, 32'h0000_1030, 1'b0};
    stim[12] = '{1'b0, 32'h0000_103C, 1'b1};
    stim[13] = '{1'b0, 32'h0000_2038, 1'b0};
    stim[14] = '{1'b0, 32'h8000_00F4, 1'b1};
    stim[15] = '{1'b0, 32'h8000_00F0, 1'b0};
  endtask

  // drives one row and returns on the edge where it is accepted
  task automatic apply_row(input int r);
    @(negedge clk);
    req_valid_i   = !stim[r].cacop;
    cacop_valid_i = stim[r].cacop;
    req_addr_i    = stim[r].addr;
    cacop_addr_i  = stim[r].addr;
    @(posedge clk);
    if (stim[r].cacop) begin
      while (cacop_ready_o !== 1'b1) @(posedge clk);
    end else begin
      while (req_ready_o !== 1'b1) @(posedge clk);
      exp_q.push_back(stim[r].addr);
      flag_q.push_back(stim[r].refill);
    end
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin : main_seq
    void'($urandom(32'h2bdb));
    clk           = 1'b0;
    rst_n         = 1'b0;
    req_valid_i   = 1'b0;
    req_addr_i    = '0;
    rsp_ready_i   = 1'b1;
    cacop_valid_i = 1'b0;
    cacop_addr_i  = '0;
    ar_ready_i    = 1'b0;
    r_valid_i     = 1'b0;
    r_data_i      = '0;
    r_last_i      = 1'b0;
    errors        = 0;
    ar_count      = 0;
    ar_seen       = 0;
    rsp_count     = 0;
    done_count    = 0;
    done_expect   = 1'b0;
    exp_refills   = 0;
    exp_cacops    = 0;
    exp_fetches   = 0;
    load_table();
    for (int r = 0; r < num_rows; r++) begin
      exp_refills += int'(stim[r].refill);
      exp_cacops  += int'(stim[r].cacop);
      exp_fetches += int'(!stim[r].cacop);
    end

    repeat (8) begin
      @(posedge clk);
      check_idle_outputs();
    end
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    check_idle_outputs();

    for (int r = 0; r < num_rows; r++) begin
      apply_row(r);
    end
    @(negedge clk);
    req_valid_i   = 1'b0;
    cacop_valid_i = 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);

    check_count("ar transfers", ar_count, exp_refills);
    check_count("cacop_done pulses", done_count, exp_cacops);
    check_count("responses", rsp_count, exp_fetches);
    $display("summary: %0d errors, %0d responses, %0d refills, %0d cache ops",
             errors, rsp_count, ar_count, done_count);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // response back-pressure, dropped about one cycle in four
  initial begin : ready_gen
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      rsp_ready_i = ($urandom_range(3, 0) != 0);
    end
  end

  // ==========================================================================
  // AXI read responder
  // ==========================================================================
  initial begin : axi_responder
    addr_t base;
    int    gap;
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      while (ar_valid_o !== 1'b1) @(posedge clk);
      gap = $urandom_range(3, 0);
      repeat (gap) @(posedge clk);
      @(negedge clk);
      ar_ready_i = 1'b1;
      @(posedge clk);
      ar_count++;
      base = ar_addr_o;
      check_count("ar_len_o", int'(ar_len_o), `ICACHE_WORDS - 1);
      if (exp_q.size() == 0) begin
        errors++;
        $display("read burst requested while no fetch was outstanding at %0t", $time);
      end else begin
        check_addr("ar_addr_o", ar_addr_o, line_base(exp_q[0]));
      end
      @(negedge clk);
      ar_ready_i = 1'b0;
      for (int b = 0; b < `ICACHE_WORDS; b++) begin
        gap       = $urandom_range(2, 0);
        r_valid_i = 1'b0;
        repeat (gap) @(negedge clk);
        r_valid_i = 1'b1;
        r_data_i  = mem_word(base + addr_t'(4 * b));
        r_last_i  = (b == `ICACHE_WORDS - 1);
        @(posedge clk);
        while (r_ready_o !== 1'b1) @(posedge clk);
        @(negedge clk);
      end
      r_valid_i = 1'b0;
      r_last_i  = 1'b0;
    end
  end

  // responses in order, refills counted between consecutive responses
  always @(posedge clk) begin : monitor
    addr_t a;
    logic  f;
    if (rst_n) begin
      check_bit("cacop_done_o", cacop_done_o, done_expect);
      if (cacop_done_o === 1'b1) begin
        done_count++;
      end
      done_expect = cacop_valid_i && cacop_ready_o;
      if (rsp_valid_o && rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("response seen with no fetch outstanding at %0t", $time);
        end else begin
          a = exp_q.pop_front();
          f = flag_q.pop_front();
          check_addr("rsp_addr_o", rsp_addr_o, a);
          check_word("rsp_instr_o", rsp_instr_o, mem_word(a));
          check_count("refills for fetch", ar_count - ar_seen, int'(f));
          ar_seen = ar_count;
          rsp_count++;
        end
      end
    end
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("run stopped by timeout, %0d fetches still waiting", exp_q.size());
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* hw/icache_defs.svh */
// instruction cache geometry and address field macros
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// ==========================================================================
// geometry
// ==========================================================================
`define ICACHE_ADDR_WIDTH 32
`define ICACHE_WAY_NUM    2
// bytes per line
`define ICACHE_BLOCK_SIZE 16
`define ICACHE_SETS       16
`define ICACHE_WORDS      (`ICACHE_BLOCK_SIZE / 4)

`define ICACHE_OFS_WIDTH  4
`define ICACHE_IDX_WIDTH  4
`define ICACHE_TAG_WIDTH  (`ICACHE_ADDR_WIDTH - `ICACHE_IDX_WIDTH - `ICACHE_OFS_WIDTH)

// ==========================================================================
// address fields, argument must be a plain signal name
// ==========================================================================
`define ICACHE_IDX_OF(a)  a[`ICACHE_OFS_WIDTH +: `ICACHE_IDX_WIDTH]
`define ICACHE_TAG_OF(a)  a[`ICACHE_ADDR_WIDTH - 1 -: `ICACHE_TAG_WIDTH]
`define ICACHE_WORD_OF(a) a[`ICACHE_OFS_WIDTH - 1:2]
`define ICACHE_LINE_ALIGN(a) \
  {a[`ICACHE_ADDR_WIDTH - 1:`ICACHE_OFS_WIDTH], {`ICACHE_OFS_WIDTH{1'b0}}}

`endif

/* hw/icache_lookup.sv */
// two-stage lookup pipeline: tag match, PLRU, memory control, cache op, response
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_lookup (
  input  logic              clk,
  input  logic              rst_n,
  // fetch
  input  logic              req_valid_i,
  input  icache_pkg::addr_t req_addr_i,
  output logic              req_ready_o,
  output logic              rsp_valid_o,
  output icache_pkg::addr_t rsp_addr_o,
  output icache_pkg::word_t rsp_instr_o,
  input  logic              rsp_ready_i,
  // index invalidate
  input  logic              cacop_valid_i,
  input  icache_pkg::addr_t cacop_addr_i,
  output logic              cacop_ready_o,
  output logic              cacop_done_o,
  // memories and refill engine
  ram_port_if.ctrl_mp       tag0,
  ram_port_if.ctrl_mp       tag1,
  ram_port_if.ctrl_mp       data0,
  ram_port_if.ctrl_mp       data1,
  refill_if.lookup_mp       rf
);
  import icache_pkg::*;

  addr_t      s1_addr_q;
  logic       s1_fetch_q;
  logic       s1_cacop_q;
  logic       replay_q;
  way_t       plru_q [`ICACHE_SETS];

  logic       advance;
  idx_t       s1_idx;
  idx_t       rd_idx;
  tag_entry_t tag_rd [`ICACHE_WAY_NUM];
  line_t      line_rd [`ICACHE_WAY_NUM];
  logic [`ICACHE_WAY_NUM-1:0] match_oh;
  logic       hit;
  way_t       hit_way;
  line_t      hit_line;
  way_t       victim;
  way_t       cacop_way;
  tag_entry_t tag_wdata;
  logic [`ICACHE_WAY_NUM-1:0] tag_we;
  logic [`ICACHE_WAY_NUM-1:0] data_we;

  // ========================================================================
  // stage 0
  // ========================================================================
  // stage 1 moves on when empty, on a cache op, or when its hit is taken
  assign advance       = !s1_fetch_q || (rsp_valid_o && rsp_ready_i);
  assign cacop_ready_o = advance;
  // cache op wins over fetch
  assign req_ready_o   = advance && !cacop_valid_i;

  // held request keeps reading its own set
  always_comb begin
    if (!advance) begin
      rd_idx = `ICACHE_IDX_OF(s1_addr_q);
    end else if (cacop_valid_i) begin
      rd_idx = `ICACHE_IDX_OF(cacop_addr_i);
    end else begin
      rd_idx = `ICACHE_IDX_OF(req_addr_i);
    end
  end

  // ========================================================================
  // stage 1
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_fetch_q <= 1'b0;
      s1_cacop_q <= 1'b0;
      replay_q   <= 1'b0;
    end else begin
      if (advance) begin
        s1_fetch_q <= req_valid_i && !cacop_valid_i;
        s1_cacop_q <= cacop_valid_i;
      end
      // one bubble so the new line is read back before the repeat
      replay_q <= rf.fill_done;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s1_addr_q <= cacop_valid_i ? cacop_addr_i : req_addr_i;
    end
  end

  assign s1_idx     = `ICACHE_IDX_OF(s1_addr_q);
  assign tag_rd[0]  = tag0.rdata;
  assign tag_rd[1]  = tag1.rdata;
  assign line_rd[0] = data0.rdata;
  assign line_rd[1] = data1.rdata;

  always_comb begin
    hit_way = '0;
    for (int i = 0; i < `ICACHE_WAY_NUM; i++) begin
      match_oh[i] = tag_rd[i].valid && (tag_rd[i].tag == `ICACHE_TAG_OF(s1_addr_q));
      if (match_oh[i]) begin
        hit_way = way_t'(i);
      end
    end
  end

  assign hit      = |match_oh;
  assign hit_line = line_rd[hit_way];

  assign rsp_valid_o  = s1_fetch_q && hit && !replay_q;
  assign rsp_addr_o   = s1_addr_q;
  assign rsp_instr_o  = hit_line[`ICACHE_WORD_OF(s1_addr_q)];
  assign cacop_done_o = s1_cacop_q;

  // pseudo-LRU, one bit per set pointing at the next victim
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        plru_q[s] <= '0;
      end
    end else if (rsp_valid_o && rsp_ready_i) begin
      plru_q[s1_idx] <= ~hit_way;
    end
  end

  assign victim = plru_q[s1_idx];

  // ========================================================================
  // refill request and memory writes
  // ========================================================================
  assign rf.start     = s1_fetch_q && !hit && !replay_q && !rf.busy;
  assign rf.line_addr = `ICACHE_LINE_ALIGN(s1_addr_q);

  // low address bits of the cache op pick the way
  assign cacop_way = way_t'(s1_addr_q);

  always_comb begin
    tag_wdata.valid = !s1_cacop_q;
    tag_wdata.tag   = s1_cacop_q ? '0 : `ICACHE_TAG_OF(s1_addr_q);
    for (int i = 0; i < `ICACHE_WAY_NUM; i++) begin
      data_we[i] = rf.fill_done && (victim == way_t'(i));
      tag_we[i]  = data_we[i] || (s1_cacop_q && (cacop_way == way_t'(i)));
    end
  end

  assign tag0.we     = tag_we[0];
  assign tag0.waddr  = s1_idx;
  assign tag0.wdata  = tag_wdata;
  assign tag0.raddr  = rd_idx;
  assign tag1.we     = tag_we[1];
  assign tag1.waddr  = s1_idx;
  assign tag1.wdata  = tag_wdata;
  assign tag1.raddr  = rd_idx;

  assign data0.we    = data_we[0];
  assign data0.waddr = s1_idx;
  assign data0.wdata = rf.fill_line;
  assign data0.raddr = rd_idx;
  assign data1.we    = data_we[1];
  assign data1.waddr = s1_idx;
  assign data1.wdata = rf.fill_line;
  assign data1.raddr = rd_idx;

endmodule

/* hw/icache_pkg.sv */
// shared address, word, line, tag entry and refill state types
`include "icache_defs.svh"

package icache_pkg;

  // byte address, no translation
  typedef logic [`ICACHE_ADDR_WIDTH-1:0] addr_t;

  // one instruction
  typedef logic [31:0] word_t;

  // whole cache line, word 0 at the lowest address
  typedef word_t [`ICACHE_WORDS-1:0] line_t;

  typedef logic [`ICACHE_IDX_WIDTH-1:0] idx_t;

  typedef logic [$clog2(`ICACHE_WAY_NUM)-1:0] way_t;

  // valid bit and tag live in one memory word
  typedef struct packed {
    logic                         valid;
    logic [`ICACHE_TAG_WIDTH-1:0] tag;
  } tag_entry_t;

  // refill engine states
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    FILL
  } refill_state_e;

endpackage

/* hw/icache_refill.sv */
// refill engine with AXI read burst request and beat collection into a line
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_refill (
  input  logic              clk,
  input  logic              rst_n,
  refill_if.refill_mp       rf,
  // AR channel
  output logic              ar_valid_o,
  output icache_pkg::addr_t ar_addr_o,
  output logic [7:0]        ar_len_o,
  input  logic              ar_ready_i,
  // R channel
  input  logic              r_valid_i,
  input  icache_pkg::word_t r_data_i,
  input  logic              r_last_i,
  output logic              r_ready_o
);
  import icache_pkg::*;

  localparam int beat_w = $clog2(`ICACHE_WORDS);

  refill_state_e     state_q;
  addr_t             line_addr_q;
  logic [beat_w-1:0] beat_q;
  line_t             line_buf_q;
  logic              beat_fire;
  logic              last_fire;

  assign beat_fire = (state_q == FILL) && r_valid_i;
  assign last_fire = beat_fire && r_last_i;

  // ========================================================================
  // state machine
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (rf.start) begin
            state_q <= REQ;
          end
        end
        REQ: begin
          if (ar_ready_i) begin
            state_q <= FILL;
          end
        end
        FILL: begin
          if (last_fire) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // beat position inside the current burst
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_q <= '0;
    end else if (state_q != FILL) begin
      beat_q <= '0;
    end else if (beat_fire) begin
      beat_q <= beat_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && rf.start) begin
      line_addr_q <= rf.line_addr;
    end
    if (beat_fire) begin
      line_buf_q[beat_q] <= r_data_i;
    end
  end

  // ========================================================================
  // outputs
  // ========================================================================
  assign ar_valid_o = (state_q == REQ);
  assign ar_addr_o  = line_addr_q;
  // incrementing burst over the whole line
  assign ar_len_o   = 8'(`ICACHE_WORDS - 1);
  assign r_ready_o  = (state_q == FILL);

  assign rf.busy      = (state_q != IDLE);
  assign rf.fill_done = last_fire;

  // last beat merged straight from the R channel
  always_comb begin
    rf.fill_line         = line_buf_q;
    rf.fill_line[beat_q] = r_data_i;
  end

endmodule

/* hw/icache_top.sv */
// instruction cache top level: lookup, refill engine and per-way memories
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_top (
  input  logic              clk,
  input  logic              rst_n,
  // fetch request
  input  logic              req_valid_i,
  input  icache_pkg::addr_t req_addr_i,
  output logic              req_ready_o,
  // fetch response
  output logic              rsp_valid_o,
  output icache_pkg::addr_t rsp_addr_o,
  output icache_pkg::word_t rsp_instr_o,
  input  logic              rsp_ready_i,
  // cache op, bit 0 of the address selects the way
  input  logic              cacop_valid_i,
  input  icache_pkg::addr_t cacop_addr_i,
  output logic              cacop_ready_o,
  output logic              cacop_done_o,
  // AXI read address
  output logic              ar_valid_o,
  output icache_pkg::addr_t ar_addr_o,
  output logic [7:0]        ar_len_o,
  input  logic              ar_ready_i,
  // AXI read data
  input  logic              r_valid_i,
  input  icache_pkg::word_t r_data_i,
  input  logic              r_last_i,
  output logic              r_ready_o
);
  import icache_pkg::*;

  ram_port_if #(.entry_t(tag_entry_t)) tag_port0 ();
  ram_port_if #(.entry_t(tag_entry_t)) tag_port1 ();
  ram_port_if #(.entry_t(line_t))      data_port0 ();
  ram_port_if #(.entry_t(line_t))      data_port1 ();
  refill_if                            rf_bus ();

  // ========================================================================
  // pipeline and refill
  // ========================================================================
  icache_lookup u_lookup (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .req_ready_o   (req_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_addr_o    (rsp_addr_o),
    .rsp_instr_o   (rsp_instr_o),
    .rsp_ready_i   (rsp_ready_i),
    .cacop_valid_i (cacop_valid_i),
    .cacop_addr_i  (cacop_addr_i),
    .cacop_ready_o (cacop_ready_o),
    .cacop_done_o  (cacop_done_o),
    .tag0          (tag_port0.ctrl_mp),
    .tag1          (tag_port1.ctrl_mp),
    .data0         (data_port0.ctrl_mp),
    .data1         (data_port1.ctrl_mp),
    .rf            (rf_bus.lookup_mp)
  );

  icache_refill u_refill (
    .clk        (clk),
    .rst_n      (rst_n),
    .rf         (rf_bus.refill_mp),
    .ar_valid_o (ar_valid_o),
    .ar_addr_o  (ar_addr_o),
    .ar_len_o   (ar_len_o),
    .ar_ready_i (ar_ready_i),
    .r_valid_i  (r_valid_i),
    .r_data_i   (r_data_i),
    .r_last_i   (r_last_i),
    .r_ready_o  (r_ready_o)
  );

  // ========================================================================
  // per-way tag and data memories
  // ========================================================================
  sdp_ram #(.entry_t(tag_entry_t), .DEPTH(`ICACHE_SETS)) u_tag_ram0 (
    .clk (clk), .rst_n (rst_n), .port (tag_port0.ram_mp)
  );

  sdp_ram #(.entry_t(tag_entry_t), .DEPTH(`ICACHE_SETS)) u_tag_ram1 (
    .clk (clk), .rst_n (rst_n), .port (tag_port1.ram_mp)
  );

  sdp_ram #(.entry_t(line_t), .DEPTH(`ICACHE_SETS)) u_data_ram0 (
    .clk (clk), .rst_n (rst_n), .port (data_port0.ram_mp)
  );

  sdp_ram #(.entry_t(line_t), .DEPTH(`ICACHE_SETS)) u_data_ram1 (
    .clk (clk), .rst_n (rst_n), .port (data_port1.ram_mp)
  );

endmodule

/* hw/ram_port_if.sv */
// memory port bundle and refill handshake bundle
`timescale 1ns/1ps

// ==========================================================================
// one write port and one read port of a cache memory
// ==========================================================================
interface ram_port_if #(
  parameter type entry_t = logic
);
  import icache_pkg::*;

  logic   we;
  idx_t   waddr;
  entry_t wdata;
  idx_t   raddr;
  entry_t rdata;

  modport ctrl_mp (output we, output waddr, output wdata, output raddr, input rdata);
  modport ram_mp  (input we, input waddr, input wdata, input raddr, output rdata);
endinterface

// ==========================================================================
// lookup to refill engine
// ==========================================================================
interface refill_if;
  import icache_pkg::*;

  // level request accepted only while the engine is idle
  logic  start;
  addr_t line_addr;
  logic  busy;
  // one-cycle pulse that qualifies fill_line
  logic  fill_done;
  line_t fill_line;

  modport lookup_mp (output start, output line_addr,
                     input busy, input fill_done, input fill_line);
  modport refill_mp (input start, input line_addr,
                     output busy, output fill_done, output fill_line);
endinterface

/* hw/sdp_ram.sv */
// simple dual-port memory with registered write-first read
`timescale 1ns/1ps

module sdp_ram #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = 16
) (
  input logic        clk,
  input logic        rst_n,
  ram_port_if.ram_mp port
);

  entry_t mem [DEPTH];
  entry_t rdata_q;

  // contents cleared so every entry starts invalid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      rdata_q <= '0;
    end else begin
      if (port.we) begin
        mem[port.waddr] <= port.wdata;
      end
      // write-first on an address collision
      if (port.we && (port.waddr == port.raddr)) begin
        rdata_q <= port.wdata;
      end else begin
        rdata_q <= mem[port.raddr];
      end
    end
  end

  assign port.rdata = rdata_q;

endmodule

/* icache_top.f */
+incdir+hw
hw/icache_pkg.sv
hw/ram_port_if.sv
hw/sdp_ram.sv
hw/icache_refill.sv
hw/icache_lookup.sv
hw/icache_top.sv
bench/icache_tb.sv
